// ==== fifo_geom_pkg.sv ====
//--------------------------------------
// FIFO geometry
// RAM depth, address and occupancy widths
// and the types built on them
//--------------------------------------

package fifo_geom_pkg;

   //--------------------------------------
   // Sizes
   //--------------------------------------
   localparam int unsigned DEPTH  = 16;               // RAM entries
   localparam int unsigned ADDR_W = $clog2(DEPTH);    // 4 bits for 16 entries

   // One extra bit so a full RAM (DEPTH) is representable
   localparam int unsigned CNT_W  = ADDR_W + 1;

   //--------------------------------------
   // Types
   //--------------------------------------
   typedef logic [ADDR_W-1:0] addr_t;    // External RAM address
   typedef logic [CNT_W-1:0]  cnt_t;     // Words held, 0 to DEPTH

endpackage

// ==== fifo_flag_pkg.sv ====
//--------------------------------------
// FIFO flag thresholds
// Static levels for almost full and
// almost empty
//--------------------------------------

package fifo_flag_pkg;

   // Almost full is set at or above this occupancy
   localparam int unsigned AFULL_VAL  = 14;

   // Almost empty is set at or below this occupancy
   localparam int unsigned AEMPTY_VAL = 2;

endpackage

// ==== fifo_wr_ctrl.sv ====
//--------------------------------------
// FIFO write-side controller
// Accepts writes while not full, keeps the
// RAM write address and registers the
// write acknowledge and overflow pulses
//--------------------------------------

`timescale 1ns/100ps

module fifo_wr_ctrl
   import fifo_geom_pkg::*;
(
   input  logic  pos_clk,
   input  logic  aresetn,
   input  logic  we_i,           // Write request level
   input  logic  full_i,         // Registered full flag
   output logic  wr_accept_o,    // Write strobe to RAM and status
   output addr_t memwaddr_o,     // RAM write address
   output logic  wack_o,         // One cycle after an accepted write
   output logic  overflow_o      // One cycle after a refused write
);

   // A write while full is dropped and never touches the address
   assign wr_accept_o = we_i & ~full_i;

   //--------------------------------------
   // Write address counter
   //--------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         memwaddr_o <= '0;
      end else if (wr_accept_o) begin
         if (memwaddr_o == addr_t'(DEPTH - 1)) begin
            memwaddr_o <= '0;                  // Wrap to first entry
         end else begin
            memwaddr_o <= memwaddr_o + 1'b1;
         end
      end
   end

   //--------------------------------------
   // Per-access pulses
   //--------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o     <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         wack_o     <= wr_accept_o;
         overflow_o <= we_i & full_i;     // Request lost
      end
   end

endmodule

// ==== fifo_rd_ctrl.sv ====
//--------------------------------------
// FIFO read-side controller
// Accepts reads while not empty, keeps the
// RAM read address and registers the
// data valid and underflow pulses
//--------------------------------------

`timescale 1ns/100ps

module fifo_rd_ctrl
   import fifo_geom_pkg::*;
(
   input  logic  pos_clk,
   input  logic  aresetn,
   input  logic  re_i,           // Read request level
   input  logic  empty_i,        // Registered empty flag
   output logic  rd_accept_o,    // Read strobe to RAM and status
   output addr_t memraddr_o,     // RAM read address
   output logic  dvld_o,         // RAM data valid, one cycle after accept
   output logic  underflow_o     // One cycle after a refused read
);

   // Reading an empty FIFO is refused, address stays put
   assign rd_accept_o = re_i & ~empty_i;

   //--------------------------------------
   // Read address counter
   //--------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         memraddr_o <= '0;
      end else if (rd_accept_o) begin
         if (memraddr_o == addr_t'(DEPTH - 1)) begin
            memraddr_o <= '0;                  // Wrap to first entry
         end else begin
            memraddr_o <= memraddr_o + 1'b1;
         end
      end
   end

   //--------------------------------------
   // Per-access pulses
   //--------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_o      <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         dvld_o      <= rd_accept_o;      // RAM output is ready next cycle
         underflow_o <= re_i & empty_i;
      end
   end

endmodule

// ==== fifo_status.sv ====
//--------------------------------------
// FIFO status unit
// Tracks the occupancy from the write and
// read accept strobes and registers the
// full, almost full, empty and almost
// empty flags from the next occupancy
//--------------------------------------

`timescale 1ns/100ps

module fifo_status
   import fifo_geom_pkg::*, fifo_flag_pkg::*;
(
   input  logic pos_clk,
   input  logic aresetn,
   input  logic wr_accept_i,    // Accepted write this cycle
   input  logic rd_accept_i,    // Accepted read this cycle
   output cnt_t wrcnt_o,        // Words currently held
   output logic full_o,
   output logic afull_o,
   output logic empty_o,
   output logic aempty_o
);

   cnt_t cnt_nxt;               // Occupancy after this edge
   logic full_nxt;
   logic afull_nxt;
   logic empty_nxt;
   logic aempty_nxt;

   //--------------------------------------
   // Next occupancy
   //--------------------------------------
   // The controllers already refuse a write
   // while full and a read while empty, so
   // the count cannot leave 0..DEPTH here
   always_comb begin
      case ({wr_accept_i, rd_accept_i})
         2'b10:   cnt_nxt = wrcnt_o + 1'b1;
         2'b01:   cnt_nxt = wrcnt_o - 1'b1;
         default: cnt_nxt = wrcnt_o;       // Idle, or write and read together
      endcase
   end

   //--------------------------------------
   // Flag decode
   //--------------------------------------
   // All four come from cnt_nxt so they line
   // up with the registered count
   assign full_nxt   = (cnt_nxt == cnt_t'(DEPTH));
   assign empty_nxt  = (cnt_nxt == '0);
   assign afull_nxt  = (cnt_nxt >= cnt_t'(AFULL_VAL));
   assign aempty_nxt = (cnt_nxt <= cnt_t'(AEMPTY_VAL));

   //--------------------------------------
   // Occupancy register
   //--------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wrcnt_o <= '0;
      end else begin
         wrcnt_o <= cnt_nxt;
      end
   end

   //--------------------------------------
   // Flag registers
   //--------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         empty_o  <= 1'b1;       // Comes out of reset empty
         aempty_o <= 1'b1;
      end else begin
         full_o   <= full_nxt;
         afull_o  <= afull_nxt;
         empty_o  <= empty_nxt;
         aempty_o <= aempty_nxt;
      end
   end

endmodule

// ==== fifo_sync_ctrl.sv ====
//--------------------------------------
// Synchronous FIFO controller
// Drives the address and strobes of an
// external RAM and reports occupancy,
// level flags and per-access pulses
//--------------------------------------

`timescale 1ns/100ps

module fifo_sync_ctrl
   import fifo_geom_pkg::*;
(
   input  logic  pos_clk,
   input  logic  aresetn,
   input  logic  we_i,
   input  logic  re_i,
   output logic  full_o,
   output logic  afull_o,
   output logic  empty_o,
   output logic  aempty_o,
   output cnt_t  wrcnt_o,
   output logic  wack_o,
   output logic  dvld_o,
   output logic  overflow_o,
   output logic  underflow_o,
   output addr_t memwaddr_o,
   output logic  memwe_o,
   output addr_t memraddr_o,
   output logic  memre_o
);

   logic wr_accept;    // Accepted write, also the RAM write strobe
   logic rd_accept;    // Accepted read, also the RAM read strobe

   assign memwe_o = wr_accept;
   assign memre_o = rd_accept;

   fifo_wr_ctrl u_wr_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .full_i      (full_o),
      .wr_accept_o (wr_accept),
      .memwaddr_o  (memwaddr_o),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .empty_i     (empty_o),
      .rd_accept_o (rd_accept),
      .memraddr_o  (memraddr_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   // Flags feed back to gate the two controllers
   fifo_status u_status (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .wrcnt_o     (wrcnt_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o)
   );

endmodule

// ==== tb_fifo_sync_ctrl.sv ====
//--------------------------------------
// Testbench for the synchronous FIFO
// controller. Drives biased random writes
// and reads and checks every output
// against a cycle model
//--------------------------------------

`timescale 1ns/100ps

module tb_fifo_sync_ctrl
   import fifo_geom_pkg::*, fifo_flag_pkg::*;
();

   // Expected accepts plus the registered state after an edge
   typedef struct packed {
      logic  wacc;
      logic  racc;
      addr_t waddr;
      addr_t raddr;
      cnt_t  cnt;
      logic  full;
      logic  afull;
      logic  empty;
      logic  aempty;
      logic  wack;
      logic  dvld;
      logic  ovf;
      logic  udf;
   } model_t;

   localparam int WAIT_MAX = 500;    // Cycles allowed to reach a flag

   logic   pos_clk;
   logic   aresetn;
   logic   we_i;
   logic   re_i;
   logic   full_o, afull_o, empty_o, aempty_o;
   cnt_t   wrcnt_o;
   logic   wack_o, dvld_o, overflow_o, underflow_o;
   addr_t  memwaddr_o, memraddr_o;
   logic   memwe_o, memre_o;

   model_t m;                        // Model state after the last edge
   model_t nxt;
   int     errors = 0;
   int     checks = 0;

   fifo_sync_ctrl u_dut (.*);

   always #50 pos_clk = ~pos_clk;

   //--------------------------------------
   // Reference model
   //--------------------------------------
   function automatic model_t predict(cnt_t cnt, addr_t wa, addr_t ra, logic we, logic re);
      model_t n;
      int     occ;
      n.wacc  = we && (int'(cnt) != DEPTH);
      n.racc  = re && (int'(cnt) != 0);
      n.waddr = n.wacc ? addr_t'((int'(wa) + 1) % DEPTH) : wa;
      n.raddr = n.racc ? addr_t'((int'(ra) + 1) % DEPTH) : ra;
      occ     = int'(cnt) + (n.wacc ? 1 : 0) - (n.racc ? 1 : 0);
      n.cnt    = cnt_t'(occ);
      n.full   = (occ == DEPTH);
      n.afull  = (occ >= AFULL_VAL);
      n.empty  = (occ == 0);
      n.aempty = (occ <= AEMPTY_VAL);
      n.wack   = n.wacc;
      n.dvld   = n.racc;
      n.ovf    = we && (int'(cnt) == DEPTH);    // Lost write
      n.udf    = re && (int'(cnt) == 0);        // Lost read
      return n;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   //--------------------------------------
   // Compare process
   //--------------------------------------
   // Runs mid-cycle, where inputs and registered outputs are settled
   always @(negedge pos_clk) begin
      if (!aresetn) begin
         m        = '0;
         m.empty  = 1'b1;
         m.aempty = 1'b1;
      end else begin
         nxt = predict(m.cnt, m.waddr, m.raddr, we_i, re_i);
         check("wrcnt_o",     wrcnt_o,     m.cnt);
         check("memwaddr_o",  memwaddr_o,  m.waddr);
         check("memraddr_o",  memraddr_o,  m.raddr);
         check("full_o",      full_o,      m.full);
         check("afull_o",     afull_o,     m.afull);
         check("empty_o",     empty_o,     m.empty);
         check("aempty_o",    aempty_o,    m.aempty);
         check("wack_o",      wack_o,      m.wack);
         check("dvld_o",      dvld_o,      m.dvld);
         check("overflow_o",  overflow_o,  m.ovf);
         check("underflow_o", underflow_o, m.udf);
         check("memwe_o",     memwe_o,     nxt.wacc);    // Same-cycle strobes
         check("memre_o",     memre_o,     nxt.racc);
         m = nxt;                                        // State after next edge
      end
   end

   //--------------------------------------
   // Stimulus helpers
   //--------------------------------------
   function automatic logic roll(input int pct);
      return ($urandom % 100) < pct;
   endfunction

   task automatic drive(input logic we, input logic re);
      @(posedge pos_clk);
      #10;
      we_i = we;
      re_i = re;
   endtask

   // Biased traffic until full_o or empty_o shows up
   task automatic run_until(input bit to_full, input int wr_pct, input int rd_pct);
      int n;
      for (n = 0; n < WAIT_MAX; n++) begin
         if (to_full ? full_o : empty_o) break;
         drive(roll(wr_pct), roll(rd_pct));
      end
      if (n == WAIT_MAX) begin
         errors++;
         $display("Timed out waiting for %s to rise", to_full ? "full_o" : "empty_o");
      end
   endtask

   //--------------------------------------
   // Test sequence
   //--------------------------------------
   initial begin
      pos_clk = 1'b0;
      aresetn = 1'b0;
      we_i    = 1'b0;
      re_i    = 1'b0;
      void'($urandom(14));
      repeat (3) @(posedge pos_clk);
      #10 aresetn = 1'b1;

      drive(1'b0, 1'b1);             // Read on empty, underflow
      drive(1'b0, 1'b0);
      run_until(1'b1, 100, 0);       // Fill to full
      drive(1'b1, 1'b0);             // Writes while full are refused
      drive(1'b1, 1'b0);
      drive(1'b0, 1'b0);
      run_until(1'b0, 0, 100);       // Drain to empty
      repeat (8) drive(1'b1, 1'b0);  // Mid level
      repeat (6) drive(1'b1, 1'b1);  // Count holds, both addresses move

      run_until(1'b1, 80, 20);       // Fill-heavy
      run_until(1'b0, 20, 80);       // Drain-heavy
      repeat (2000) drive(roll(50), roll(50));
      drive(1'b0, 1'b0);
      drive(1'b0, 1'b0);
      @(negedge pos_clk);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
fifo_geom_pkg.sv
fifo_flag_pkg.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
fifo_status.sv
fifo_sync_ctrl.sv
tb_fifo_sync_ctrl.sv

// ==== Bender.yml ====
package:
  name: fifo_sync_ctrl

sources:
  # Packages first, then the blocks, then the top level
  - fifo_geom_pkg.sv
  - fifo_flag_pkg.sv
  - fifo_wr_ctrl.sv
  - fifo_rd_ctrl.sv
  - fifo_status.sv
  - fifo_sync_ctrl.sv

  - target: test
    files:
      - tb_fifo_sync_ctrl.sv
